// ==== common/miss_pkg.sv ====
package miss_pkg;

  // cache geometry.
  localparam int ADDR_W      = 32;
  localparam int WAYS        = 4;
  localparam int SETS        = 16;
  localparam int BLOCK_WORDS = 4;
  localparam int WORD_BYTES  = 4;
  localparam int INDEX_W     = $clog2(SETS);
  localparam int OFFSET_W    = $clog2(BLOCK_WORDS * WORD_BYTES);
  localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WAY_W       = $clog2(WAYS);

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [WAY_W-1:0]   way_id_t;
  typedef logic [WAYS-1:0]    way_vec_t;

  // node 0 is the root of the pseudo-tree, and a 0 points the LRU side to the lower ways.
  typedef logic [WAYS-2:0]    lru_bits_t;

  typedef enum logic [2:0] {
    OP_LD,
    OP_ST,
    OP_AFL,
    OP_AINV,
    OP_AFLINV,
    OP_ALOCK,
    OP_AUNLOCK
  } op_e;

  typedef enum logic [2:0] {
    DMA_NOP,
    DMA_FILL_ADDR,
    DMA_EVICT_ADDR,
    DMA_EVICT_DATA,
    DMA_FILL_DATA
  } dma_cmd_e;

  typedef enum logic [3:0] {
    START,
    FLUSH_OP,
    LOCK_OP,
    SEND_FILL_ADDR,
    SEND_EVICT_ADDR,
    SEND_EVICT_DATA,
    GET_FILL_DATA,
    RECOVER,
    DONE
  } miss_state_e;

  typedef struct packed {
    op_e                op;
    addr_t              addr;
    tag_t [WAYS-1:0]    tags;
    way_vec_t           valid;
    way_vec_t           lock;
    way_vec_t           hit;
    way_id_t            hit_way;
    logic               hit_found;
  } miss_req_t;

  typedef struct packed {
    way_vec_t  dirty;
    lru_bits_t lru_bits;
  } stat_info_t;

  typedef struct packed {
    logic valid;
    logic lock;
    tag_t tag;
  } tag_info_t;

  typedef struct packed {
    logic                 v;
    logic                 w;
    index_t               index;
    tag_info_t [WAYS-1:0] data;
    tag_info_t [WAYS-1:0] mask;
  } tag_wr_t;

  typedef struct packed {
    logic       v;
    logic       w;
    index_t     index;
    stat_info_t data;
    stat_info_t mask;
  } stat_wr_t;

  typedef struct packed {
    dma_cmd_e cmd;
    way_id_t  way;
    addr_t    addr;
  } dma_req_t;

endpackage

// ==== replacement/victim_select.sv ====
`timescale 1ns/10ps

module victim_select (
  input  miss_pkg::way_vec_t    valid_i,
  input  miss_pkg::way_vec_t    lock_i,
  input  miss_pkg::stat_info_t  stat_i,
  output miss_pkg::way_id_t     victim_way_o,
  output logic                  victim_dirty_o
);

  miss_pkg::way_id_t invalid_way;
  logic              invalid_found;
  miss_pkg::way_id_t lru_way;

  // lowest way that is both invalid and unlocked.
  always_comb begin
    invalid_found = 1'b0;
    invalid_way   = '0;
    for (int w = miss_pkg::WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w] && !lock_i[w]) begin
        invalid_found = 1'b1;
        invalid_way   = miss_pkg::way_id_t'(w);
      end
    end
  end

  // walk the tree from the root. A node follows its stored bit unless every
  // way under that side is locked, then it turns to the other side.
  always_comb begin
    int   node;
    int   prefix;
    logic side;
    logic side_locked;

    node   = 0;
    prefix = 0;
    for (int lvl = 0; lvl < miss_pkg::WAY_W; lvl++) begin
      side        = stat_i.lru_bits[node];
      side_locked = 1'b1;
      for (int w = 0; w < miss_pkg::WAYS; w++) begin
        if ((w >> (miss_pkg::WAY_W - 1 - lvl)) == (prefix * 2 + side)) begin
          side_locked = side_locked & lock_i[w];
        end
      end
      if (side_locked) begin
        side = ~side;
      end
      prefix = prefix * 2 + side;
      node   = node * 2 + 1 + side;
    end
    lru_way = miss_pkg::way_id_t'(prefix);
  end

  assign victim_way_o   = invalid_found ? invalid_way : lru_way;
  assign victim_dirty_o = stat_i.dirty[victim_way_o] & valid_i[victim_way_o];

endmodule

// ==== replacement/meta_write.sv ====
`timescale 1ns/10ps

module meta_write (
  input  miss_pkg::miss_state_e  state_i,
  input  miss_pkg::miss_req_t    req_i,
  input  miss_pkg::way_id_t      chosen_way_i,
  input  miss_pkg::way_id_t      flush_way_i,
  input  logic                   dma_done_i,
  input  logic                   miss_v_i,
  input  logic                   sbuf_empty_i,
  output miss_pkg::tag_wr_t      tag_wr_o,
  output miss_pkg::stat_wr_t     stat_wr_o
);

  miss_pkg::way_vec_t  chosen_dec;
  miss_pkg::way_vec_t  flush_dec;
  miss_pkg::lru_bits_t lru_data;
  miss_pkg::lru_bits_t lru_mask;
  miss_pkg::tag_t      req_tag;
  logic                inv_op;

  assign chosen_dec = miss_pkg::way_vec_t'(1) << chosen_way_i;
  assign flush_dec  = miss_pkg::way_vec_t'(1) << flush_way_i;
  assign req_tag    = req_i.addr[miss_pkg::ADDR_W-1 -: miss_pkg::TAG_W];
  assign inv_op     = (req_i.op == miss_pkg::OP_AINV) || (req_i.op == miss_pkg::OP_AFLINV);

  // the nodes on the chosen way's path point away from it, the rest keep their value.
  always_comb begin
    int   node;
    logic way_bit;

    lru_data = '0;
    lru_mask = '0;
    node     = 0;
    for (int lvl = 0; lvl < miss_pkg::WAY_W; lvl++) begin
      way_bit        = chosen_way_i[miss_pkg::WAY_W - 1 - lvl];
      lru_data[node] = ~way_bit;
      lru_mask[node] = 1'b1;
      node           = node * 2 + 1 + way_bit;
    end
  end

  always_comb begin
    tag_wr_o        = '0;
    stat_wr_o       = '0;
    tag_wr_o.index  = req_i.addr[miss_pkg::OFFSET_W +: miss_pkg::INDEX_W];
    stat_wr_o.index = req_i.addr[miss_pkg::OFFSET_W +: miss_pkg::INDEX_W];

    case (state_i)
      // status read for the set of the incoming request.
      miss_pkg::START: begin
        stat_wr_o.v = miss_v_i & sbuf_empty_i;
      end

      miss_pkg::FLUSH_OP: begin
        stat_wr_o.v          = 1'b1;
        stat_wr_o.w          = 1'b1;
        stat_wr_o.mask.dirty = flush_dec;
        tag_wr_o.v           = 1'b1;
        tag_wr_o.w           = 1'b1;
        for (int i = 0; i < miss_pkg::WAYS; i++) begin
          tag_wr_o.mask[i].valid = inv_op & flush_dec[i];
          tag_wr_o.mask[i].lock  = inv_op & flush_dec[i];
        end
      end

      miss_pkg::LOCK_OP: begin
        tag_wr_o.v = 1'b1;
        tag_wr_o.w = 1'b1;
        for (int i = 0; i < miss_pkg::WAYS; i++) begin
          tag_wr_o.data[i].lock = (req_i.op == miss_pkg::OP_ALOCK);
          tag_wr_o.mask[i].lock = req_i.hit[i];
        end
      end

      // the new block goes in on the last fill beat and becomes MRU.
      miss_pkg::GET_FILL_DATA: begin
        stat_wr_o.v             = dma_done_i;
        stat_wr_o.w             = 1'b1;
        stat_wr_o.data.dirty    = {miss_pkg::WAYS{req_i.op == miss_pkg::OP_ST}};
        stat_wr_o.data.lru_bits = lru_data;
        stat_wr_o.mask.dirty    = chosen_dec;
        stat_wr_o.mask.lru_bits = lru_mask;
        tag_wr_o.v              = dma_done_i;
        tag_wr_o.w              = 1'b1;
        for (int i = 0; i < miss_pkg::WAYS; i++) begin
          tag_wr_o.data[i].valid = 1'b1;
          tag_wr_o.data[i].lock  = 1'b0;
          tag_wr_o.data[i].tag   = req_tag;
          tag_wr_o.mask[i].valid = chosen_dec[i];
          tag_wr_o.mask[i].lock  = chosen_dec[i];
          tag_wr_o.mask[i].tag   = {miss_pkg::TAG_W{chosen_dec[i]}};
        end
      end

      default: begin
        tag_wr_o.v  = 1'b0;
        stat_wr_o.v = 1'b0;
      end
    endcase
  end

endmodule

// ==== source/miss_fsm.sv ====
`timescale 1ns/10ps

module miss_fsm (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   miss_v_i,
  input  miss_pkg::miss_req_t    req_i,
  input  logic                   sbuf_empty_i,
  input  miss_pkg::way_id_t      victim_way_i,
  input  logic                   victim_dirty_i,
  input  miss_pkg::way_vec_t     stat_dirty_i,
  input  logic                   dma_done_i,
  input  logic                   ack_i,
  output miss_pkg::dma_req_t     dma_o,
  output miss_pkg::miss_state_e  state_o,
  output miss_pkg::way_id_t      chosen_way_o,
  output miss_pkg::way_id_t      flush_way_o,
  output logic                   recover_o,
  output logic                   done_o
);

  miss_pkg::miss_state_e state_r, state_n;
  miss_pkg::way_id_t     chosen_way_r, chosen_way_n;
  miss_pkg::way_id_t     flush_way_r, flush_way_n;
  miss_pkg::way_id_t     evict_way;
  miss_pkg::index_t      index;
  miss_pkg::addr_t       fill_addr;
  miss_pkg::addr_t       evict_addr;
  logic                  flush_route;
  logic                  lock_route;
  logic                  inv_only;

  assign flush_route = (req_i.op == miss_pkg::OP_AFL) || (req_i.op == miss_pkg::OP_AINV) ||
                       (req_i.op == miss_pkg::OP_AFLINV);
  assign lock_route  = (req_i.op == miss_pkg::OP_ALOCK) || (req_i.op == miss_pkg::OP_AUNLOCK);
  assign inv_only    = (req_i.op == miss_pkg::OP_AINV);

  // flush ops evict the hit way, fills evict the replacement victim.
  assign evict_way  = flush_route ? flush_way_r : chosen_way_r;
  assign index      = req_i.addr[miss_pkg::OFFSET_W +: miss_pkg::INDEX_W];
  assign fill_addr  = {req_i.addr[miss_pkg::ADDR_W-1 -: miss_pkg::TAG_W], index,
                       {miss_pkg::OFFSET_W{1'b0}}};
  assign evict_addr = {req_i.tags[evict_way], index, {miss_pkg::OFFSET_W{1'b0}}};

  assign state_o      = state_r;
  assign chosen_way_o = chosen_way_r;
  // the flush way is already in use in FLUSH_OP, the cycle it gets latched.
  assign flush_way_o  = flush_way_n;

  always_comb begin
    state_n      = state_r;
    chosen_way_n = chosen_way_r;
    flush_way_n  = flush_way_r;
    dma_o.cmd    = miss_pkg::DMA_NOP;
    dma_o.way    = evict_way;
    dma_o.addr   = '0;
    recover_o    = 1'b0;
    done_o       = 1'b0;

    case (state_r)
      miss_pkg::START: begin
        if (miss_v_i && sbuf_empty_i) begin
          if (flush_route) begin
            state_n = miss_pkg::FLUSH_OP;
          end else if (lock_route) begin
            state_n = miss_pkg::LOCK_OP;
          end else begin
            state_n = miss_pkg::SEND_FILL_ADDR;
          end
        end
      end

      miss_pkg::FLUSH_OP: begin
        flush_way_n = req_i.hit_way;
        // AINV drops the line, the flushing ops write it back if it is dirty.
        if (!inv_only && stat_dirty_i[req_i.hit_way] && req_i.valid[req_i.hit_way]) begin
          state_n = miss_pkg::SEND_EVICT_ADDR;
        end else begin
          state_n = miss_pkg::RECOVER;
        end
      end

      miss_pkg::LOCK_OP: begin
        state_n = miss_pkg::RECOVER;
      end

      miss_pkg::SEND_FILL_ADDR: begin
        chosen_way_n = victim_way_i;
        dma_o.cmd    = miss_pkg::DMA_FILL_ADDR;
        dma_o.way    = victim_way_i;
        dma_o.addr   = fill_addr;
        if (dma_done_i) begin
          state_n = victim_dirty_i ? miss_pkg::SEND_EVICT_ADDR : miss_pkg::GET_FILL_DATA;
        end
      end

      miss_pkg::SEND_EVICT_ADDR: begin
        dma_o.cmd  = miss_pkg::DMA_EVICT_ADDR;
        dma_o.addr = evict_addr;
        if (dma_done_i) begin
          state_n = miss_pkg::SEND_EVICT_DATA;
        end
      end

      miss_pkg::SEND_EVICT_DATA: begin
        dma_o.cmd  = miss_pkg::DMA_EVICT_DATA;
        dma_o.addr = evict_addr;
        if (dma_done_i) begin
          state_n = flush_route ? miss_pkg::RECOVER : miss_pkg::GET_FILL_DATA;
        end
      end

      miss_pkg::GET_FILL_DATA: begin
        dma_o.cmd  = miss_pkg::DMA_FILL_DATA;
        dma_o.addr = fill_addr;
        if (dma_done_i) begin
          state_n = miss_pkg::RECOVER;
        end
      end

      // one cycle for the pipeline to re-read the tag and data memories.
      miss_pkg::RECOVER: begin
        recover_o = 1'b1;
        state_n   = miss_pkg::DONE;
      end

      miss_pkg::DONE: begin
        done_o = 1'b1;
        if (ack_i) begin
          state_n = miss_pkg::START;
        end
      end

      default: begin
        state_n = miss_pkg::START;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r      <= miss_pkg::START;
      chosen_way_r <= '0;
      flush_way_r  <= '0;
    end else begin
      state_r      <= state_n;
      chosen_way_r <= chosen_way_n;
      flush_way_r  <= flush_way_n;
    end
  end

endmodule

// ==== source/cache_miss_unit.sv ====
`timescale 1ns/10ps

module cache_miss_unit (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  miss_v_i,
  input  miss_pkg::miss_req_t   req_i,
  input  logic                  sbuf_empty_i,
  input  miss_pkg::stat_info_t  stat_info_i,
  input  logic                  dma_done_i,
  input  logic                  ack_i,
  output miss_pkg::dma_req_t    dma_o,
  output miss_pkg::tag_wr_t     tag_wr_o,
  output miss_pkg::stat_wr_t    stat_wr_o,
  output miss_pkg::way_id_t     chosen_way_o,
  output logic                  recover_o,
  output logic                  done_o
);

  miss_pkg::miss_state_e state;
  miss_pkg::way_id_t     chosen_way;
  miss_pkg::way_id_t     flush_way;
  miss_pkg::way_id_t     victim_way;
  logic                  victim_dirty;

  assign chosen_way_o = chosen_way;

  miss_fsm fsm_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .miss_v_i       (miss_v_i),
    .req_i          (req_i),
    .sbuf_empty_i   (sbuf_empty_i),
    .victim_way_i   (victim_way),
    .victim_dirty_i (victim_dirty),
    .stat_dirty_i   (stat_info_i.dirty),
    .dma_done_i     (dma_done_i),
    .ack_i          (ack_i),
    .dma_o          (dma_o),
    .state_o        (state),
    .chosen_way_o   (chosen_way),
    .flush_way_o    (flush_way),
    .recover_o      (recover_o),
    .done_o         (done_o)
  );

  victim_select victim_i (
    .valid_i        (req_i.valid),
    .lock_i         (req_i.lock),
    .stat_i         (stat_info_i),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty)
  );

  meta_write meta_i (
    .state_i        (state),
    .req_i          (req_i),
    .chosen_way_i   (chosen_way),
    .flush_way_i    (flush_way),
    .dma_done_i     (dma_done_i),
    .miss_v_i       (miss_v_i),
    .sbuf_empty_i   (sbuf_empty_i),
    .tag_wr_o       (tag_wr_o),
    .stat_wr_o      (stat_wr_o)
  );

endmodule

// ==== verif/cache_miss_unit_props.sv ====
`timescale 1ns/10ps

module cache_miss_unit_props (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  miss_v_i,
  input miss_pkg::miss_req_t   req_i,
  input logic                  sbuf_empty_i,
  input miss_pkg::stat_info_t  stat_info_i,
  input logic                  dma_done_i,
  input logic                  ack_i,
  input miss_pkg::dma_req_t    dma_o,
  input miss_pkg::tag_wr_t     tag_wr_o,
  input miss_pkg::stat_wr_t    stat_wr_o,
  input miss_pkg::way_id_t     chosen_way_o,
  input logic                  recover_o,
  input logic                  done_o
);

  int unsigned       fail_count = 0;
  miss_pkg::way_id_t exp_way;
  miss_pkg::way_id_t evict_way;
  logic              exp_dirty;
  logic              fill_op;
  logic              flush_op;
  logic              lock_op;
  logic              inv_op;
  miss_pkg::tag_t    req_tag;
  miss_pkg::index_t  req_index;

  // reference replacement choice for the four-way tree.
  function automatic miss_pkg::way_id_t expect_victim(miss_pkg::way_vec_t valid,
                                                       miss_pkg::way_vec_t lock,
                                                       miss_pkg::lru_bits_t lru);
    logic top;
    logic low;
    for (int i = 0; i < 4; i++) begin
      if (!valid[i] && !lock[i]) begin
        return miss_pkg::way_id_t'(i);
      end
    end
    top = lru[0];
    if (!top && (lock[1:0] == 2'b11)) begin
      top = 1'b1;
    end else if (top && (lock[3:2] == 2'b11)) begin
      top = 1'b0;
    end
    low = top ? lru[2] : lru[1];
    if (lock[{top, low}]) begin
      low = ~low;
    end
    return {top, low};
  endfunction

  function automatic logic fill_write_ok(miss_pkg::tag_wr_t twr, miss_pkg::stat_wr_t swr,
                                         miss_pkg::way_id_t w, logic is_store,
                                         miss_pkg::tag_t tag, miss_pkg::index_t index);
    logic                ok;
    miss_pkg::lru_bits_t exp_mask;
    ok = twr.v && twr.w && swr.v && swr.w;
    ok = ok && (twr.index == index) && (swr.index == index);
    for (int i = 0; i < 4; i++) begin
      ok = ok && (twr.mask[i].valid == (i == w));
      ok = ok && (twr.mask[i].lock == (i == w));
      ok = ok && (twr.mask[i].tag == ((i == w) ? '1 : '0));
    end
    ok = ok && twr.data[w].valid && !twr.data[w].lock && (twr.data[w].tag == tag);
    ok = ok && (swr.mask.dirty == miss_pkg::way_vec_t'(1 << w));
    ok = ok && (swr.data.dirty[w] == is_store);
    exp_mask = w[1] ? 3'b101 : 3'b011;
    ok = ok && (swr.mask.lru_bits == exp_mask);
    ok = ok && (swr.data.lru_bits[0] == ~w[1]);
    ok = ok && (swr.data.lru_bits[w[1] ? 2 : 1] == ~w[0]);
    return ok;
  endfunction

  // a lock write may touch nothing but the lock bit of the hit way.
  function automatic logic lock_mask_ok(miss_pkg::tag_wr_t twr, miss_pkg::way_id_t hw);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < 4; i++) begin
      ok = ok && (twr.mask[i].lock == (i == hw)) && !twr.mask[i].valid;
      ok = ok && (twr.mask[i].tag == '0);
    end
    return ok;
  endfunction

  assign fill_op   = (req_i.op == miss_pkg::OP_LD) || (req_i.op == miss_pkg::OP_ST);
  assign inv_op    = (req_i.op == miss_pkg::OP_AINV) || (req_i.op == miss_pkg::OP_AFLINV);
  assign flush_op  = inv_op || (req_i.op == miss_pkg::OP_AFL);
  assign lock_op   = (req_i.op == miss_pkg::OP_ALOCK) || (req_i.op == miss_pkg::OP_AUNLOCK);
  assign exp_way   = expect_victim(req_i.valid, req_i.lock, stat_info_i.lru_bits);
  assign exp_dirty = stat_info_i.dirty[exp_way] && req_i.valid[exp_way];
  assign evict_way = fill_op ? exp_way : req_i.hit_way;
  assign req_tag   = req_i.addr[miss_pkg::ADDR_W-1 -: miss_pkg::TAG_W];
  assign req_index = req_i.addr[miss_pkg::OFFSET_W +: miss_pkg::INDEX_W];

  clean_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd == miss_pkg::DMA_FILL_ADDR && dma_done_i && !exp_dirty
    |=> dma_o.cmd == miss_pkg::DMA_FILL_DATA)
    else begin
      $error("clean fill did not go to fill data");
      fail_count++;
    end

  fill_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd == miss_pkg::DMA_FILL_ADDR |-> dma_o.addr == {req_tag, req_index, 4'h0})
    else begin
      $error("fill address wrong");
      fail_count++;
    end

  dirty_evict: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd == miss_pkg::DMA_FILL_ADDR && dma_done_i && exp_dirty
    |=> dma_o.cmd == miss_pkg::DMA_EVICT_ADDR)
    else begin
      $error("dirty victim not evicted");
      fail_count++;
    end

  evict_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd == miss_pkg::DMA_EVICT_ADDR
    |-> dma_o.addr == {req_i.tags[evict_way], req_index, 4'h0})
    else begin
      $error("eviction address wrong");
      fail_count++;
    end

  // every DMA command names the way that is filled or written back.
  dma_way: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd != miss_pkg::DMA_NOP |-> dma_o.way == evict_way)
    else begin
      $error("DMA way wrong");
      fail_count++;
    end

  evict_order: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd == miss_pkg::DMA_EVICT_ADDR && dma_done_i
    |=> dma_o.cmd == miss_pkg::DMA_EVICT_DATA)
    else begin
      $error("evict data did not follow evict address");
      fail_count++;
    end

  evict_then_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd == miss_pkg::DMA_EVICT_DATA && dma_done_i && fill_op
    |=> dma_o.cmd == miss_pkg::DMA_FILL_DATA)
    else begin
      $error("fill data did not follow eviction");
      fail_count++;
    end

  victim_choice: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd == miss_pkg::DMA_FILL_DATA
    |-> chosen_way_o == exp_way && !req_i.lock[chosen_way_o])
    else begin
      $error("victim way wrong");
      fail_count++;
    end

  fill_update: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd == miss_pkg::DMA_FILL_DATA && dma_done_i
    |-> fill_write_ok(tag_wr_o, stat_wr_o, chosen_way_o, req_i.op == miss_pkg::OP_ST,
                      req_tag, req_index))
    else begin
      $error("fill metadata write wrong");
      fail_count++;
    end

  // flush and lock ops only use DMA to write back a dirty hit line.
  dma_allowed: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd != miss_pkg::DMA_NOP
    |-> fill_op || ((req_i.op == miss_pkg::OP_AFL || req_i.op == miss_pkg::OP_AFLINV)
        && stat_info_i.dirty[req_i.hit_way] && req_i.valid[req_i.hit_way]
        && (dma_o.cmd == miss_pkg::DMA_EVICT_ADDR || dma_o.cmd == miss_pkg::DMA_EVICT_DATA)))
    else begin
      $error("unexpected DMA command");
      fail_count++;
    end

  flush_write: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_wr_o.v && flush_op
    |-> stat_wr_o.v && stat_wr_o.mask.dirty == miss_pkg::way_vec_t'(1 << req_i.hit_way)
        && !stat_wr_o.data.dirty[req_i.hit_way]
        && tag_wr_o.mask[req_i.hit_way].valid == inv_op
        && tag_wr_o.mask[req_i.hit_way].lock == inv_op
        && !tag_wr_o.data[req_i.hit_way].valid
        && !tag_wr_o.data[req_i.hit_way].lock
        && tag_wr_o.index == req_index && stat_wr_o.index == req_index)
    else begin
      $error("flush metadata write wrong");
      fail_count++;
    end

  lock_write: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_wr_o.v && lock_op
    |-> !stat_wr_o.v && lock_mask_ok(tag_wr_o, req_i.hit_way)
        && tag_wr_o.data[req_i.hit_way].lock == (req_i.op == miss_pkg::OP_ALOCK)
        && tag_wr_o.index == req_index)
    else begin
      $error("lock metadata write wrong");
      fail_count++;
    end

  reset_idle: assert property (@(posedge clk_i)
    $fell(reset_i) |-> dma_o.cmd == miss_pkg::DMA_NOP && !done_o && !recover_o
        && !tag_wr_o.v && !stat_wr_o.v)
    else begin
      $error("outputs active after reset");
      fail_count++;
    end

  recover_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    recover_o |=> !recover_o && done_o)
    else begin
      $error("recover not a single pulse before done");
      fail_count++;
    end

  done_held: assert property (@(posedge clk_i) disable iff (reset_i)
    done_o && !ack_i |=> done_o)
    else begin
      $error("done dropped before ack");
      fail_count++;
    end

  dma_held: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_o.cmd != miss_pkg::DMA_NOP && !dma_done_i |=> $stable(dma_o))
    else begin
      $error("DMA command changed before done");
      fail_count++;
    end

endmodule

// ==== verif/cache_miss_unit_tb.sv ====
`timescale 1ns/10ps

module cache_miss_unit_tb;

  localparam int NUM_REQ    = 40;
  localparam int MAX_CYCLES = NUM_REQ * 40;

  logic                 clk_i;
  logic                 reset_i;
  logic                 miss_v_i;
  miss_pkg::miss_req_t  req_i;
  logic                 sbuf_empty_i;
  miss_pkg::stat_info_t stat_info_i;
  logic                 dma_done_i;
  logic                 ack_i;
  miss_pkg::dma_req_t   dma_o;
  miss_pkg::tag_wr_t    tag_wr_o;
  miss_pkg::stat_wr_t   stat_wr_o;
  miss_pkg::way_id_t    chosen_way_o;
  logic                 recover_o;
  logic                 done_o;
  logic [15:0]          lfsr_state;
  int                   cycles;

  cache_miss_unit dut_i (.*);

  bind cache_miss_unit cache_miss_unit_props props_i (.*);

  // one Galois step per bit taken.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return bits;
  endfunction

  task automatic build_request();
    logic [2:0]        op_sel;
    miss_pkg::way_id_t hw;
    op_sel = 3'(take_bits(3));
    if (op_sel == 3'd7) begin
      op_sel = 3'd0;
    end
    req_i.op   = miss_pkg::op_e'(op_sel);
    req_i.addr = take_bits(32);
    for (int i = 0; i < miss_pkg::WAYS; i++) begin
      req_i.tags[i] = miss_pkg::tag_t'(take_bits(miss_pkg::TAG_W));
    end
    req_i.valid = miss_pkg::way_vec_t'(take_bits(4));
    req_i.lock  = miss_pkg::way_vec_t'(take_bits(4));
    // at least one way must stay unlocked for a fill.
    if (&req_i.lock) begin
      req_i.lock[2'(take_bits(2))] = 1'b0;
    end
    stat_info_i.dirty    = miss_pkg::way_vec_t'(take_bits(4));
    stat_info_i.lru_bits = miss_pkg::lru_bits_t'(take_bits(3));
    hw = miss_pkg::way_id_t'(take_bits(2));
    if (req_i.op == miss_pkg::OP_LD || req_i.op == miss_pkg::OP_ST) begin
      req_i.hit       = '0;
      req_i.hit_way   = '0;
      req_i.hit_found = 1'b0;
    end else begin
      req_i.hit       = miss_pkg::way_vec_t'(1) << hw;
      req_i.hit_way   = hw;
      req_i.hit_found = 1'b1;
      req_i.valid[hw] = 1'b1;
    end
  endtask

  // plays the DMA engine and the pipeline ack until the unit is back in START.
  task automatic run_request();
    int   dma_wait;
    int   ack_wait;
    logic finished;
    @(posedge clk_i);
    #2;
    build_request();
    miss_v_i = 1'b1;
    dma_wait = -1;
    ack_wait = -1;
    finished = 1'b0;
    while (!finished) begin
      @(posedge clk_i);
      #2;
      miss_v_i   = 1'b0;
      dma_done_i = 1'b0;
      if (ack_i) begin
        ack_i    = 1'b0;
        finished = 1'b1;
      end else begin
        if (dma_o.cmd != miss_pkg::DMA_NOP) begin
          if (dma_wait < 0) begin
            dma_wait = int'(take_bits(2));
          end
          dma_done_i = (dma_wait == 0);
          dma_wait--;
        end
        if (done_o) begin
          if (ack_wait < 0) begin
            ack_wait = int'(take_bits(2));
          end
          ack_i = (ack_wait == 0);
          ack_wait--;
        end
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
    if (dut_i.props_i.fail_count != 0) begin
      $display("[ERROR] assertions expected 0 actual %0d", dut_i.props_i.fail_count);
      $display("Result: FAILED");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    lfsr_state   = 16'd35100;
    cycles       = 0;
    reset_i      = 1'b1;
    miss_v_i     = 1'b0;
    req_i        = '0;
    sbuf_empty_i = 1'b1;
    stat_info_i  = '0;
    dma_done_i   = 1'b0;
    ack_i        = 1'b0;
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    for (int n = 0; n < NUM_REQ; n++) begin
      run_request();
    end
    repeat (2) @(posedge clk_i);
    if (dut_i.props_i.fail_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("[ERROR] assertions expected 0 actual %0d", dut_i.props_i.fail_count);
      $display("Result: FAILED");
      $fatal(1, "assertion failure");
    end
  end

endmodule

// ==== cache_miss_unit.f ====
common/miss_pkg.sv
replacement/victim_select.sv
replacement/meta_write.sv
source/miss_fsm.sv
source/cache_miss_unit.sv
verif/cache_miss_unit_props.sv
verif/cache_miss_unit_tb.sv

// ==== Bender.yml ====
package:
  name: cache_miss_unit

sources:
  - common/miss_pkg.sv
  - replacement/victim_select.sv
  - replacement/meta_write.sv
  - source/miss_fsm.sv
  - source/cache_miss_unit.sv
  - target: simulation
    files:
      - verif/cache_miss_unit_props.sv
      - verif/cache_miss_unit_tb.sv
